// File: cache_macros.svh
//************************************************
// cache geometry and memory timing constants
// tag, set and offset widths plus the byte bit must add up to ADDR_W
// MEM_LATENCY must be at least 2 for the memory delay line
//************************************************
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

`define ADDR_W          16      // byte address width
`define WORD_W          16      // cpu data word
`define TAG_W           7
`define SET_W           5
`define OFS_W           3       // word within a block
`define WAYS            4
`define SETS            32
`define WORDS_PER_BLOCK 8       // 16 byte block

`define MEM_WORDS       32768   // backing store depth in words
`define MEM_LATENCY     4       // cycles from read strobe to data valid

`endif

// File: cache_addr_pkg.sv
//************************************************
// address and data types for the cache datapath
// byte address layout is tag | set | word offset | byte bit
// the byte bit is ignored since only word accesses exist
//************************************************
`include "cache_macros.svh"

package cache_addr_pkg;

	typedef logic [`ADDR_W-1:0] addr_t;     // cpu byte address
	typedef logic [`WORD_W-1:0] word_t;     // one data word

	// address fields
	typedef logic [`TAG_W-1:0] tag_t;
	typedef logic [`SET_W-1:0] set_t;
	typedef logic [`OFS_W-1:0] ofs_t;       // word index inside a block

	// main memory is word addressed so the byte bit drops off
	typedef logic [`ADDR_W-2:0] mem_addr_t;

endpackage

// File: cache_ctrl_pkg.sv
//************************************************
// control side types for the fill FSM and replacement
//************************************************
`include "cache_macros.svh"

package cache_ctrl_pkg;

	typedef logic [`WAYS-1:0] way_oh_t;     // one bit per way, at most one set
	typedef logic [1:0] age_t;              // 3 is newest, 0 is a replacement candidate

	typedef enum logic [2:0] {
		IDLE, LOOKUP, STORE, FETCH, TAG_COMMIT, RESPOND
	} fill_state_t;

endpackage

// File: cache_tag_array.sv
//************************************************
// valid bits and tags for all ways of all sets
// read and compare are combinational on set and tag
// a tag write always sets valid, lines are only invalidated by rst
//************************************************
`timescale 1ns/10ps
`include "cache_macros.svh"

module cache_tag_array (
	input  logic                   clk,
	input  logic                   rst,
	input  cache_addr_pkg::set_t   set,
	input  cache_addr_pkg::tag_t   tag,
	input  logic                   tag_we,
	input  cache_ctrl_pkg::way_oh_t fill_way,
	output cache_ctrl_pkg::way_oh_t hit_way,
	output cache_ctrl_pkg::way_oh_t valid_ways
);
	import cache_addr_pkg::*;
	import cache_ctrl_pkg::*;

	way_oh_t valid_q [`SETS];               // one valid bit per way, per set
	tag_t tag_mem [`WAYS][`SETS];

	// valid bits come up cleared
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `SETS; s++)
				valid_q[s] <= '0;
		end else if (tag_we) begin
			valid_q[set] <= valid_q[set] | fill_way;  // fill commits the line
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < `WAYS; w++) begin
			if (tag_we && fill_way[w])
				tag_mem[w][set] <= tag;
		end
	end

	assign valid_ways = valid_q[set];

	// compare every way in parallel
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < `WAYS; w++)
			hit_way[w] = valid_q[set][w] && (tag_mem[w][set] == tag);
	end

endmodule

// File: cache_data_array.sv
//************************************************
// word storage, eight words per way and set
// way must be one-hot or zero, a zero way reads back 0
// contents are not cleared by reset
//************************************************
`timescale 1ns/10ps
`include "cache_macros.svh"

module cache_data_array (
	input  logic                    clk,
	input  cache_addr_pkg::set_t    set,
	input  cache_addr_pkg::ofs_t    ofs,
	input  cache_ctrl_pkg::way_oh_t way,
	input  logic                    we,
	input  cache_addr_pkg::word_t   wdata,
	output cache_addr_pkg::word_t   rdata
);
	import cache_addr_pkg::*;
	import cache_ctrl_pkg::*;

	word_t mem [`WAYS][`SETS][`WORDS_PER_BLOCK];

	// single write port, shared by fills and store hits
	always_ff @(posedge clk) begin
		for (int w = 0; w < `WAYS; w++) begin
			if (we && way[w])
				mem[w][set][ofs] <= wdata;
		end
	end

	// and-or mux on the one-hot way, no encoder needed
	always_comb begin
		rdata = '0;
		for (int w = 0; w < `WAYS; w++) begin
			if (way[w])
				rdata = rdata | mem[w][set][ofs];
		end
	end

endmodule

// File: cache_lru.sv
//************************************************
// age based replacement, 2 bits per way and set
// touched way goes to 3, other nonzero ages count down
// nonzero ages stay distinct so a full set always has an age 0 way
//************************************************
`timescale 1ns/10ps
`include "cache_macros.svh"

module cache_lru (
	input  logic                    clk,
	input  logic                    rst,
	input  cache_addr_pkg::set_t    set,
	input  logic                    touch,
	input  cache_ctrl_pkg::way_oh_t touch_way,
	input  cache_ctrl_pkg::way_oh_t valid_ways,
	output cache_ctrl_pkg::way_oh_t victim
);
	import cache_addr_pkg::*;
	import cache_ctrl_pkg::*;

	age_t age_q [`SETS][`WAYS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `SETS; s++)
				for (int w = 0; w < `WAYS; w++)
					age_q[s][w] <= '0;
		end else if (touch) begin
			for (int w = 0; w < `WAYS; w++) begin
				if (touch_way[w])
					age_q[set][w] <= 2'd3;                   // most recent
				else if (age_q[set][w] != 2'd0)
					age_q[set][w] <= age_q[set][w] - 2'd1;
			end
		end
	end

	// loops run high to low so the lowest matching way wins
	always_comb begin
		victim = way_oh_t'(1);                  // fallback, not reachable
		for (int w = `WAYS - 1; w >= 0; w--) begin
			if (age_q[set][w] == 2'd0)
				victim = way_oh_t'(1 << w);
		end
		// an invalid way beats any age
		for (int w = `WAYS - 1; w >= 0; w--) begin
			if (!valid_ways[w])
				victim = way_oh_t'(1 << w);
		end
	end

endmodule

// File: cache_fill_fsm.sv
//************************************************
// cache control FSM, one request at a time
// req must not pulse again before done
// load hit done after 1 cycle, store after 2, load miss after the fill
// stores are write-through and never allocate
//************************************************
`timescale 1ns/10ps
`include "cache_macros.svh"

module cache_fill_fsm (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    req,
	input  logic                    we,
	input  cache_addr_pkg::addr_t   addr,
	input  cache_addr_pkg::word_t   wdata,
	input  cache_ctrl_pkg::way_oh_t hit_way,
	input  cache_ctrl_pkg::way_oh_t victim,
	input  cache_addr_pkg::word_t   arr_rdata,
	input  logic                    mem_rvalid,
	input  cache_addr_pkg::word_t   mem_rdata,
	output logic                    done,
	output logic                    hit,
	output logic                    miss,
	output cache_addr_pkg::word_t   rdata,
	output cache_ctrl_pkg::way_oh_t arr_way,
	output cache_addr_pkg::ofs_t    arr_ofs,
	output logic                    arr_we,
	output cache_addr_pkg::word_t   arr_wdata,
	output logic                    tag_we,
	output logic                    lru_touch,
	output logic                    mem_rd,
	output logic                    mem_wr,
	output cache_addr_pkg::mem_addr_t mem_addr,
	output cache_addr_pkg::word_t   mem_wdata,
	output cache_addr_pkg::set_t    set,
	output cache_addr_pkg::tag_t    tag
);
	import cache_addr_pkg::*;
	import cache_ctrl_pkg::*;

	fill_state_t state;
	addr_t addr_q;          // held request
	word_t wdata_q;
	way_oh_t victim_q;      // frozen at miss start, LRU moves during the fill
	ofs_t cnt;              // fill word counter
	logic rd_busy;          // one memory read in flight
	logic any_hit;
	logic load_hit;
	tag_t tag_q;
	set_t set_q;
	ofs_t ofs_q;

	assign tag_q = addr_q[`ADDR_W-1:`OFS_W+`SET_W+1];
	assign set_q = addr_q[`OFS_W+`SET_W:`OFS_W+1];
	assign ofs_q = addr_q[`OFS_W:1];
	assign any_hit = |hit_way;
	assign load_hit = (state == IDLE) && req && !we && any_hit;

	// live address in the request cycle, held copy after it
	assign set = (state == IDLE) ? addr[`OFS_W+`SET_W:`OFS_W+1] : set_q;
	assign tag = (state == IDLE) ? addr[`ADDR_W-1:`OFS_W+`SET_W+1] : tag_q;

	// victim way while filling and committing, hit way otherwise
	assign arr_way = (state == FETCH || state == TAG_COMMIT) ? victim_q : hit_way;
	always_comb begin
		case (state)
			IDLE:    arr_ofs = addr[`OFS_W:1];
			FETCH:   arr_ofs = cnt;
			default: arr_ofs = ofs_q;
		endcase
	end
	assign arr_we = (state == FETCH && mem_rvalid) || (state == STORE && any_hit);
	assign arr_wdata = (state == FETCH) ? mem_rdata : wdata_q;
	assign tag_we = (state == TAG_COMMIT);  // data is all in, tag last
	assign lru_touch = load_hit || (state == STORE && any_hit) || (state == TAG_COMMIT);

	assign mem_rd = (state == FETCH) && !rd_busy;
	assign mem_wr = (state == STORE);       // every store goes to memory
	assign mem_addr = (state == FETCH) ? {tag_q, set_q, cnt} : addr_q[`ADDR_W-1:1];
	assign mem_wdata = wdata_q;
	assign done = (state == RESPOND);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			hit <= 1'b0;
			miss <= 1'b0;
			cnt <= '0;
			rd_busy <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (req && we) begin
						state <= STORE;
					end else if (load_hit) begin
						hit <= 1'b1;
						state <= RESPOND;
					end else if (req) begin
						miss <= 1'b1;   // load miss, go fill
						cnt <= '0;
						state <= FETCH;
					end
				end
				STORE: begin
					hit <= any_hit;
					state <= RESPOND;
				end
				FETCH: begin
					if (mem_rvalid) begin
						rd_busy <= 1'b0;
						cnt <= cnt + 1'b1;
						if (cnt == ofs_t'(`WORDS_PER_BLOCK - 1))
							state <= TAG_COMMIT;
					end else if (mem_rd) begin
						rd_busy <= 1'b1;
					end
				end
				TAG_COMMIT: state <= LOOKUP;
				LOOKUP: begin
					hit <= 1'b0;        // the fill answers as a miss
					state <= RESPOND;
				end
				RESPOND: begin
					miss <= 1'b0;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// request and response payload
	always_ff @(posedge clk) begin
		if (state == IDLE && req) begin
			addr_q <= addr;
			wdata_q <= wdata;
			victim_q <= victim;
		end
		if (load_hit || state == LOOKUP)
			rdata <= arr_rdata;     // re-lookup reads the freshly filled word
	end

endmodule

// File: main_memory.sv
//************************************************
// word wide backing store, 32K words
// writes land in one cycle, reads return MEM_LATENCY cycles later
// contents start unknown, the read delay line starts empty
//************************************************
`timescale 1ns/10ps
`include "cache_macros.svh"

module main_memory (
	input  logic                      clk,
	input  logic                      rd,
	input  logic                      wr,
	input  cache_addr_pkg::mem_addr_t addr,
	input  cache_addr_pkg::word_t     wdata,
	output logic                      rvalid,
	output cache_addr_pkg::word_t     rdata
);
	import cache_addr_pkg::*;

	word_t mem [`MEM_WORDS];
	logic [`MEM_LATENCY-1:0] vld_pipe = '0;
	word_t dat_pipe [`MEM_LATENCY];

	always_ff @(posedge clk) begin
		if (wr)
			mem[addr] <= wdata;
	end

	// fixed latency delay line, data sampled in the strobe cycle
	always_ff @(posedge clk) begin
		vld_pipe <= {vld_pipe[`MEM_LATENCY-2:0], rd};
		dat_pipe[0] <= mem[addr];
		for (int i = 1; i < `MEM_LATENCY; i++)
			dat_pipe[i] <= dat_pipe[i-1];
	end

	assign rvalid = vld_pipe[`MEM_LATENCY-1];
	assign rdata = dat_pipe[`MEM_LATENCY-1];     // only meaningful with rvalid

endmodule

// File: cache_top.sv
//************************************************
// data cache top with its main memory
// 4-way, 32 sets, 16 byte blocks, write-through
// cpu side is a req pulse in and a done pulse out
//************************************************
`timescale 1ns/10ps

module cache_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req,
	input  logic                  we,
	input  cache_addr_pkg::addr_t addr,
	input  cache_addr_pkg::word_t wdata,
	output logic                  done,
	output logic                  hit,
	output logic                  miss,
	output cache_addr_pkg::word_t rdata
);
	import cache_addr_pkg::*;
	import cache_ctrl_pkg::*;

	set_t set;
	tag_t tag;
	ofs_t arr_ofs;
	way_oh_t hit_way, valid_ways, victim;
	way_oh_t arr_way;                   // data way, fill way and touch way
	word_t arr_rdata, arr_wdata;
	logic arr_we, tag_we, lru_touch;
	logic mem_rd, mem_wr, mem_rvalid;
	mem_addr_t mem_addr;
	word_t mem_wdata, mem_rdata;

	cache_fill_fsm u_fsm (
		.clk(clk), .rst(rst), .req(req), .we(we), .addr(addr), .wdata(wdata),
		.hit_way(hit_way), .victim(victim), .arr_rdata(arr_rdata),
		.mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
		.done(done), .hit(hit), .miss(miss), .rdata(rdata),
		.arr_way(arr_way), .arr_ofs(arr_ofs), .arr_we(arr_we), .arr_wdata(arr_wdata),
		.tag_we(tag_we), .lru_touch(lru_touch),
		.mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.set(set), .tag(tag)
	);

	cache_tag_array u_tags (
		.clk(clk), .rst(rst), .set(set), .tag(tag), .tag_we(tag_we),
		.fill_way(arr_way), .hit_way(hit_way), .valid_ways(valid_ways)
	);

	cache_data_array u_data (
		.clk(clk), .set(set), .ofs(arr_ofs), .way(arr_way),
		.we(arr_we), .wdata(arr_wdata), .rdata(arr_rdata)
	);

	cache_lru u_lru (
		.clk(clk), .rst(rst), .set(set), .touch(lru_touch), .touch_way(arr_way),
		.valid_ways(valid_ways), .victim(victim)
	);

	main_memory u_mem (
		.clk(clk), .rd(mem_rd), .wr(mem_wr), .addr(mem_addr), .wdata(mem_wdata),
		.rvalid(mem_rvalid), .rdata(mem_rdata)
	);

endmodule

// File: cache_assertions.sv
//************************************************
// protocol checks, bound into cache_top
// assumes reset is only applied while the cache is idle
//************************************************
`timescale 1ns/10ps
`include "cache_macros.svh"

module cache_assertions (
	input logic clk,
	input logic rst,
	input logic req,
	input logic done,
	input logic mem_rd,
	input logic mem_rvalid
);
	logic pending;      // set by an accepted req, cleared by its done
	int fail_count;     // failed assertions so far

	always_ff @(posedge clk) begin
		if (rst)
			pending <= 1'b0;
		else if (req)
			pending <= 1'b1;
		else if (done)
			pending <= 1'b0;
	end

	// cpu must wait for done before the next request
	req_while_pending: assert property (@(posedge clk) disable iff (rst) req |-> !pending)
		else begin
			$error("req pulsed while an access was still pending");
			fail_count++;
		end

	// fixed read latency, checks both early and late data
	mem_read_latency: assert property (@(posedge clk) disable iff (rst)
		mem_rvalid == $past(mem_rd, `MEM_LATENCY))
		else begin
			$error("mem_rvalid not MEM_LATENCY cycles after mem_rd");
			fail_count++;
		end

	done_single_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else begin
			$error("done stayed high for more than one cycle");
			fail_count++;
		end

endmodule

bind cache_top cache_assertions u_assertions (
	.clk(clk), .rst(rst), .req(req), .done(done),
	.mem_rd(mem_rd), .mem_rvalid(mem_rvalid)
);

// File: tb_cache_top.sv
//************************************************
// testbench for cache_top, stimulus from cache_input.txt
// inputs change 1 ns after the rising edge, one access at a time
// loads only touch words stored earlier, memory starts unknown
//************************************************
`timescale 1ns/10ps
`include "cache_macros.svh"

module tb_cache_top;
	import cache_addr_pkg::*;

	localparam int TIMEOUT = `WORDS_PER_BLOCK * (`MEM_LATENCY + 2) + 20;  // covers a full fill

	logic clk;
	logic rst;
	logic req;
	logic we;
	addr_t addr;
	word_t wdata;
	logic done;
	logic hit;
	logic miss;
	word_t rdata;

	int errors;
	int checks;

	cache_top uut (
		.clk(clk), .rst(rst), .req(req), .we(we), .addr(addr), .wdata(wdata),
		.done(done), .hit(hit), .miss(miss), .rdata(rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;      // 8 ns period
	end

	// 4 rising edges with rst high
	task automatic apply_reset;
		rst = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, exp, got);
			errors++;
		end
	endtask

	// one req pulse, lat is cycles from req to done, 0 on timeout
	task automatic do_access(input logic is_store, input addr_t a, input word_t d,
			output int lat);
		@(posedge clk);
		#1;
		req = 1'b1;
		we = is_store;
		addr = a;
		wdata = d;
		@(posedge clk);
		#1;
		req = 1'b0;         // strobe, one cycle only
		we = 1'b0;
		lat = 1;
		while (!done && lat <= TIMEOUT) begin
			@(posedge clk);
			#1;
			lat++;
		end
		if (!done)
			lat = 0;
	endtask

	initial begin
		int fd;
		int r;
		int lat;
		int exp_hit;
		logic [8*8-1:0] op;         // W store, R load, X reset
		logic [8*128-1:0] skip;     // rest of a comment line
		addr_t a;
		word_t d;
		word_t exp_d;
		logic stop_run;

		errors = 0;
		checks = 0;
		req = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		stop_run = 1'b0;
		apply_reset();

		fd = $fopen("cache_input.txt", "r");
		if (fd == 0) begin
			$display("could not open cache_input.txt");
			errors++;
			stop_run = 1'b1;
		end
		while (!stop_run) begin
			r = $fscanf(fd, "%s", op);
			if (r != 1) begin
				stop_run = 1'b1;    // end of file
			end else if (op == "#") begin
				r = $fgets(skip, fd);
			end else begin
				r = $fscanf(fd, "%h %h %h %d", a, d, exp_d, exp_hit);
				if (op == "X") begin
					apply_reset();
				end else if (op == "W" || op == "R") begin
					do_access(op == "W", a, d, lat);
					if (lat == 0) begin
						$display("timeout: no done for access to address %h", a);
						errors++;
						stop_run = 1'b1;
					end else if (op == "W") begin
						check_value("hit", exp_hit, hit);
						check_value("latency", 2, lat);     // store is always 2 cycles
					end else begin
						check_value("hit", exp_hit, hit);
						check_value("miss", (exp_hit == 0), miss);
						check_value("rdata", exp_d, rdata);
						if (exp_hit != 0)
							check_value("latency", 1, lat);
					end
				end else begin
					$display("unknown operation in cache_input.txt, address %h", a);
					errors++;
				end
			end
		end
		if (fd != 0)
			$fclose(fd);

		if (uut.u_assertions.fail_count != 0) begin
			$display("protocol assertions failed %0d times", uut.u_assertions.fail_count);
			errors += uut.u_assertions.fail_count;
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: cache_top.f
+incdir+.
cache_addr_pkg.sv
cache_ctrl_pkg.sv
cache_tag_array.sv
cache_data_array.sv
cache_lru.sv
cache_fill_fsm.sv
main_memory.sv
cache_top.sv
cache_assertions.sv
tb_cache_top.sv

// File: run_sim.sh
#!/bin/sh
# builds the cache testbench with Verilator and runs it
# the run passes only when the testbench prints its pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cache_top -f cache_top.f -o sim_cache
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_cache)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "No errors"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: cache_input.txt
# columns: op (W store, R load, X reset) addr wdata exp_rdata exp_hit, values in hex
# exp_rdata is only checked on loads, set 3 holds blocks A=tag1 B=tag2 C=tag3 D=tag4 E=tag5
W 0234 1111 0000 0
R 0234 0000 1111 0
R 0234 0000 1111 1
W 0234 2222 0000 1
R 0234 0000 2222 1
W 0430 ba50 0000 0
W 0432 ba51 0000 0
W 0434 ba52 0000 0
W 0436 ba53 0000 0
W 0438 ba54 0000 0
W 043a ba55 0000 0
W 043c ba56 0000 0
W 043e ba57 0000 0
R 0430 0000 ba50 0
R 0432 0000 ba51 1
R 0434 0000 ba52 1
R 0436 0000 ba53 1
R 0438 0000 ba54 1
R 043a 0000 ba55 1
R 043c 0000 ba56 1
R 043e 0000 ba57 1
W 0634 c333 0000 0
W 0834 d444 0000 0
W 0a34 e555 0000 0
R 0634 0000 c333 0
R 0834 0000 d444 0
R 0a34 0000 e555 0
R 0234 0000 2222 0
R 0834 0000 d444 1
X 0000 0000 0000 0
R 0834 0000 d444 0
R 043a 0000 ba55 0
